// File: include/rs_params.svh
`ifndef RS_PARAMS_SVH
`define RS_PARAMS_SVH

//////////////////////////////////////////////////
// reservation-station sizing
//////////////////////////////////////////////////

// data word of the lc-3b core.
`define WORD_WIDTH 16

// producer tag, 0 marks a value that is present.
`define TAG_WIDTH 3

// ALU stations own tags 1..RS_COUNT, keep below 2**TAG_WIDTH.
`define RS_COUNT 3

`endif

// File: verilog/lc3b_types.sv
`include "rs_params.svh"

package lc3b_types;

	typedef logic [`WORD_WIDTH-1:0] lc3b_word;
	typedef logic [`TAG_WIDTH-1:0] lc3b_tag;
	typedef logic [$clog2(`RS_COUNT)-1:0] rs_index;

	typedef enum logic [1:0] {
		op_add,
		op_and,
		op_not
	} lc3b_aluop;

	typedef enum logic [1:0] {
		st_free,
		st_wait,
		st_ready,
		st_issued
	} rs_state;

	// one issued ALU instruction, vk unused for not.
	typedef struct packed {
		lc3b_aluop op;
		lc3b_word vj;
		lc3b_tag qj;
		lc3b_word vk;
		lc3b_tag qk;
	} issue_pkt;

	typedef struct packed {
		logic valid;
		lc3b_tag tag;
		lc3b_word data;
	} cdb_pkt;

	typedef struct packed {
		lc3b_aluop op;
		lc3b_word vj;
		lc3b_word vk;
		lc3b_tag tag; // station that owns the result.
	} dispatch_pkt;

endpackage : lc3b_types

// File: verilog/rs_alloc.sv
`include "rs_params.svh"

module rs_alloc (
	input logic clk,
	input logic rst_n,
	input logic issue_valid,
	input logic [`RS_COUNT-1:0] station_free,
	output logic issue_ready,
	output logic [`RS_COUNT-1:0] load_en
);

	logic [`RS_COUNT-1:0] pick;

	//////////////////////////////////////////////////
	// station choice
	//////////////////////////////////////////////////

	assign issue_ready = |station_free; // any free station takes the issue.

	// isolate the lowest set bit.
	assign pick = station_free & (~station_free + 1'b1);

	assign load_en = issue_valid ? pick : '0; // only on a handshake.

endmodule : rs_alloc

// File: verilog/alu_res_station.sv
`include "rs_params.svh"

module alu_res_station #(
	parameter int STATION_TAG = 1
) (
	input logic clk,
	input logic rst_n,
	input logic flush,
	input logic load,
	input lc3b_types::issue_pkt issue,
	input lc3b_types::cdb_pkt snoop_a,
	input lc3b_types::cdb_pkt snoop_b,
	input logic dispatched,
	output logic free,
	output logic ready,
	output lc3b_types::dispatch_pkt disp
);

	import lc3b_types::*;

	// q == 0 means v holds the operand value.
	typedef struct packed {
		lc3b_tag q;
		lc3b_word v;
	} opnd_slot;

	localparam lc3b_tag own_tag = lc3b_tag'(STATION_TAG);

	rs_state state;
	lc3b_aluop op;
	opnd_slot opr_j;
	opnd_slot opr_k;
	opnd_slot load_j; // issue operands after snooping.
	opnd_slot load_k;
	opnd_slot held_j; // stored operands after snooping.
	opnd_slot held_k;

	// replace a waiting tag by the data of a matching broadcast.
	function automatic opnd_slot snoop_fill(input lc3b_tag q, input lc3b_word v,
			input cdb_pkt a, input cdb_pkt b);
		opnd_slot r;
		r.q = q;
		r.v = v;
		if (q != '0 && a.valid && a.tag == q)
		begin
			r.q = '0;
			r.v = a.data;
		end
		else if (q != '0 && b.valid && b.tag == q)
		begin
			r.q = '0;
			r.v = b.data;
		end
		return r;
	endfunction

	assign load_j = snoop_fill(issue.qj, issue.vj, snoop_a, snoop_b);
	assign load_k = snoop_fill((issue.op == op_not) ? lc3b_tag'(0) : issue.qk, issue.vk,
			snoop_a, snoop_b); // not has no second source.
	assign held_j = snoop_fill(opr_j.q, opr_j.v, snoop_a, snoop_b);
	assign held_k = snoop_fill(opr_k.q, opr_k.v, snoop_a, snoop_b);

	//////////////////////////////////////////////////
	// station FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n || flush)
		begin
			state <= st_free;
		end
		else
		begin
			case (state)
				st_free: if (load)
					state <= (load_j.q == '0 && load_k.q == '0) ? st_ready : st_wait;
				st_wait: if (held_j.q == '0 && held_k.q == '0)
					state <= st_ready;
				st_ready: if (dispatched)
					state <= st_issued;
				st_issued: if (snoop_b.valid && snoop_b.tag == own_tag)
					state <= st_free; // own result accepted.
				default: state <= st_free;
			endcase
		end
	end

	// opcode and operands.
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			op <= issue.op;
			opr_j <= load_j;
			opr_k <= load_k;
		end
		else if (state == st_wait)
		begin
			opr_j <= held_j;
			opr_k <= held_k;
		end
	end

	assign free = (state == st_free);
	assign ready = (state == st_ready);
	assign disp = '{op: op, vj: opr_j.v, vk: opr_k.v, tag: own_tag};

endmodule : alu_res_station

// File: verilog/rs_select.sv
`include "rs_params.svh"

module rs_select (
	input logic clk,
	input logic rst_n,
	input logic flush,
	input logic [`RS_COUNT-1:0] ready,
	input lc3b_types::dispatch_pkt disp_in [`RS_COUNT],
	input logic disp_ready,
	output logic disp_valid,
	output lc3b_types::dispatch_pkt disp_out,
	output logic [`RS_COUNT-1:0] dispatched
);

	import lc3b_types::*;

	rs_index ptr; // first station to look at.
	rs_index sel;
	logic found;

	//////////////////////////////////////////////////
	// round-robin search from ptr
	//////////////////////////////////////////////////

	always_comb
	begin
		int j;
		found = 1'b0;
		sel = ptr;
		for (int i = 0; i < `RS_COUNT; i++)
		begin
			j = int'(ptr) + i;
			if (j >= `RS_COUNT)
				j = j - `RS_COUNT; // wrap around.
			if (!found && ready[j])
			begin
				found = 1'b1;
				sel = rs_index'(j);
			end
		end
	end

	assign disp_valid = found;
	assign disp_out = disp_in[sel];

	always_comb
	begin
		dispatched = '0;
		if (found && disp_ready)
			dispatched[sel] = 1'b1; // the ALU takes it this edge.
	end

	// move past the granted station so none starves.
	always_ff @(posedge clk)
	begin
		if (!rst_n || flush)
		begin
			ptr <= '0;
		end
		else if (found && disp_ready)
		begin
			ptr <= (sel == rs_index'(`RS_COUNT - 1)) ? rs_index'(0) : sel + 1'b1;
		end
	end

endmodule : rs_select

// File: verilog/alu_exec.sv
`include "rs_params.svh"

module alu_exec (
	input logic clk,
	input logic rst_n,
	input logic flush,
	input logic disp_valid,
	input lc3b_types::dispatch_pkt disp_in,
	input logic cdb_ready,
	output logic disp_ready,
	output lc3b_types::cdb_pkt cdb_out
);

	import lc3b_types::*;

	lc3b_word alu_result;
	logic res_valid;
	lc3b_tag res_tag;
	lc3b_word res_data;

	always_comb
	begin
		case (disp_in.op)
			op_add: alu_result = disp_in.vj + disp_in.vk;
			op_and: alu_result = disp_in.vj & disp_in.vk;
			op_not: alu_result = ~disp_in.vj;
			default: alu_result = disp_in.vj;
		endcase
	end

	// take a new op when empty or draining.
	assign disp_ready = !res_valid || cdb_ready;

	//////////////////////////////////////////////////
	// result register
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n || flush)
			res_valid <= 1'b0;
		else if (disp_ready)
			res_valid <= disp_valid;
	end

	always_ff @(posedge clk)
	begin
		if (disp_ready && disp_valid)
		begin
			res_tag <= disp_in.tag;
			res_data <= alu_result;
		end
	end

	assign cdb_out = '{valid: res_valid, tag: res_tag, data: res_data}; // held until taken.

endmodule : alu_exec

// File: verilog/alu_rs_unit.sv
`include "rs_params.svh"

module alu_rs_unit (
	input logic clk,
	input logic rst_n,
	input logic flush,
	input logic issue_valid,
	input lc3b_types::issue_pkt issue,
	output logic issue_ready,
	input lc3b_types::cdb_pkt cdb_in,
	input logic cdb_out_ready,
	output lc3b_types::cdb_pkt cdb_out
);

	import lc3b_types::*;

	cdb_pkt snoop_a;
	cdb_pkt snoop_b; // own broadcast, only when accepted.
	logic [`RS_COUNT-1:0] station_free;
	logic [`RS_COUNT-1:0] station_ready;
	logic [`RS_COUNT-1:0] load_en;
	logic [`RS_COUNT-1:0] dispatched;
	dispatch_pkt disp_bus [`RS_COUNT];
	logic disp_valid;
	logic disp_ready;
	dispatch_pkt alu_op;

	assign snoop_a = cdb_in;
	assign snoop_b = '{valid: cdb_out.valid & cdb_out_ready, tag: cdb_out.tag,
			data: cdb_out.data};

	rs_alloc i_rs_alloc (
		.clk(clk),
		.rst_n(rst_n),
		.issue_valid(issue_valid),
		.station_free(station_free),
		.issue_ready(issue_ready),
		.load_en(load_en)
	);

	//////////////////////////////////////////////////
	// station array, tags 1..RS_COUNT
	//////////////////////////////////////////////////

	for (genvar g = 0; g < `RS_COUNT; g++)
	begin : g_station
		alu_res_station #(.STATION_TAG(g + 1)) i_station (
			.clk(clk),
			.rst_n(rst_n),
			.flush(flush),
			.load(load_en[g]),
			.issue(issue),
			.snoop_a(snoop_a),
			.snoop_b(snoop_b),
			.dispatched(dispatched[g]),
			.free(station_free[g]),
			.ready(station_ready[g]),
			.disp(disp_bus[g])
		);
	end

	rs_select i_rs_select (
		.clk(clk),
		.rst_n(rst_n),
		.flush(flush),
		.ready(station_ready),
		.disp_in(disp_bus),
		.disp_ready(disp_ready),
		.disp_valid(disp_valid),
		.disp_out(alu_op),
		.dispatched(dispatched)
	);

	alu_exec i_alu_exec (
		.clk(clk),
		.rst_n(rst_n),
		.flush(flush),
		.disp_valid(disp_valid),
		.disp_in(alu_op),
		.cdb_ready(cdb_out_ready),
		.disp_ready(disp_ready),
		.cdb_out(cdb_out)
	);

endmodule : alu_rs_unit

// File: tests/alu_rs_tb.sv
`include "rs_params.svh"

module alu_rs_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import lc3b_types::*;

	typedef struct packed {
		lc3b_tag q;
		lc3b_word v;
	} operand_t;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 10;
	localparam int N_OPS = 290; // issues over all phases.
	localparam int WATCHDOG_CYCLES = (RESET_CYCLES + N_OPS * 3) * 4 + 1000;

	logic clk;
	logic rst_n;
	logic flush;
	logic issue_valid;
	logic issue_ready;
	issue_pkt issue;
	cdb_pkt cdb_in;
	logic cdb_out_ready;
	cdb_pkt cdb_out;

	// reference model indexed by station tag.
	logic busy [8];
	lc3b_aluop op_m [8];
	operand_t opj_m [8];
	operand_t opk_m [8];
	int busy_count;
	int n_issued;
	int n_done;
	int n_flushed;
	lc3b_word exp_data;
	logic accepted;

	string test_name;
	logic [31:0] lfsr_state;
	int ready_mode; // 0 random gaps, 1 always ready, 2 stalled.

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	alu_rs_unit i_alu_rs_unit (
		.clk(clk),
		.rst_n(rst_n),
		.flush(flush),
		.issue_valid(issue_valid),
		.issue(issue),
		.issue_ready(issue_ready),
		.cdb_in(cdb_in),
		.cdb_out_ready(cdb_out_ready),
		.cdb_out(cdb_out)
	);

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	// galois lfsr stepped once per bit taken.
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
		end
		return r;
	endfunction

	function automatic lc3b_word alu_ref(input lc3b_aluop op, input lc3b_word a,
			input lc3b_word b);
		case (op)
			op_add: return a + b;
			op_and: return a & b;
			op_not: return ~a;
			default: return '0;
		endcase
	endfunction

	// operand after this cycle's broadcasts.
	function automatic operand_t wake(input operand_t o);
		operand_t r;
		r = o;
		if (o.q != '0 && cdb_in.valid && cdb_in.tag == o.q)
		begin
			r.q = '0;
			r.v = cdb_in.data;
		end
		else if (o.q != '0 && accepted && cdb_out.tag == o.q)
		begin
			r.q = '0;
			r.v = cdb_out.data;
		end
		return r;
	endfunction

	task automatic report_mismatch(input string name, input lc3b_word expv,
			input lc3b_word actv);
		$display("mismatch %s expected %h actual %h", name, expv, actv);
		$display("Test failures found");
		$fatal(1, "stopped at the first failing check");
	endtask

	task automatic report_error(input string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1, "stopped at the first failing check");
	endtask

	//////////////////////////////////////////////////
	// model update and checks
	//////////////////////////////////////////////////

	assign accepted = cdb_out.valid && cdb_out_ready;

	always_comb
	begin
		busy_count = 0;
		for (int t = 1; t <= `RS_COUNT; t++)
			busy_count += int'(busy[t]);
		exp_data = alu_ref(op_m[cdb_out.tag], opj_m[cdb_out.tag].v, opk_m[cdb_out.tag].v);
	end

	always @(posedge clk)
	begin
		int slot;
		operand_t nj;
		operand_t nk;
		if (!rst_n || flush)
		begin
			for (int t = 0; t < 8; t++)
				busy[t] <= 1'b0;
			n_flushed <= rst_n ? n_flushed + busy_count : 0;
			if (!rst_n)
			begin
				n_issued <= 0;
				n_done <= 0;
			end
		end
		else
		begin
			for (int t = 1; t <= `RS_COUNT; t++)
			begin
				opj_m[t] <= wake(opj_m[t]);
				opk_m[t] <= wake(opk_m[t]);
			end
			if (accepted)
			begin
				busy[cdb_out.tag] <= 1'b0;
				n_done <= n_done + 1;
			end
			if (issue_valid && issue_ready)
			begin
				slot = 0;
				for (int t = `RS_COUNT; t >= 1; t--)
					if (!busy[t])
						slot = t; // lowest free station.
				nj.q = issue.qj;
				nj.v = issue.vj;
				nk.q = (issue.op == op_not) ? lc3b_tag'(0) : issue.qk;
				nk.v = issue.vk;
				busy[slot] <= 1'b1;
				op_m[slot] <= issue.op;
				opj_m[slot] <= wake(nj);
				opk_m[slot] <= wake(nk);
				n_issued <= n_issued + 1;
			end
		end
	end

	a_result: assert property (@(posedge clk) disable iff (!rst_n)
			accepted |-> cdb_out.data == exp_data)
		else report_mismatch(test_name, $sampled(exp_data), $sampled(cdb_out.data));

	a_tag: assert property (@(posedge clk) disable iff (!rst_n)
			cdb_out.valid |-> cdb_out.tag >= 1 && cdb_out.tag <= `RS_COUNT
				&& busy[cdb_out.tag] && opj_m[cdb_out.tag].q == '0
				&& opk_m[cdb_out.tag].q == '0)
		else report_error("result tag has no outstanding instruction with known operands");

	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
			cdb_out.valid && !cdb_out_ready && !flush |=> $stable(cdb_out))
		else report_error("cdb_out changed while it was stalled");

	a_occupancy: assert property (@(posedge clk) disable iff (!rst_n)
			issue_ready == (busy_count < `RS_COUNT))
		else report_error("issue_ready does not match the number of occupied stations");

	a_flush: assert property (@(posedge clk) disable iff (!rst_n)
			flush |=> !cdb_out.valid && issue_ready)
		else report_error("cdb_out valid or issue_ready low in the cycle after flush");

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	// external cdb traffic on tags 4..7 and the output ready.
	task automatic drive_cycle();
		cdb_in.valid = (take_bits(2) != '0);
		cdb_in.tag = lc3b_tag'(4 + take_bits(2));
		cdb_in.data = lc3b_word'(take_bits(16));
		case (ready_mode)
			1: cdb_out_ready = 1'b1;
			2: cdb_out_ready = 1'b0;
			default: cdb_out_ready = (take_bits(2) != '0);
		endcase
	endtask

	function automatic lc3b_tag busy_station();
		int start;
		int t;
		start = int'(take_bits(2)) % `RS_COUNT;
		for (int i = 0; i < `RS_COUNT; i++)
		begin
			t = (start + i) % `RS_COUNT + 1;
			if (busy[t])
				return lc3b_tag'(t);
		end
		return '0; // nothing in flight.
	endfunction

	function automatic lc3b_tag pick_source(input int mode);
		logic [1:0] sel;
		lc3b_tag t;
		sel = 2'(take_bits(2));
		t = '0;
		if (mode >= 2 && sel == 2'd3)
			t = busy_station();
		else if (mode >= 1 && sel[1])
			t = lc3b_tag'(4 + take_bits(2));
		return t;
	endfunction

	// the packet is built once a station is free, so station tags stay valid.
	task automatic issue_one(input int mode);
		issue_pkt p;
		@(negedge clk);
		drive_cycle();
		while (!issue_ready)
		begin
			issue_valid = 1'b0;
			@(negedge clk);
			drive_cycle();
		end
		p.op = lc3b_aluop'(take_bits(2) % 3);
		p.vj = lc3b_word'(take_bits(16));
		p.qj = pick_source(mode);
		p.vk = lc3b_word'(take_bits(16));
		p.qk = pick_source(mode);
		issue = p;
		issue_valid = 1'b1;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles)
		begin
			@(negedge clk);
			drive_cycle();
			issue_valid = 1'b0;
		end
	endtask

	task automatic drain();
		do
			idle(1);
		while (busy_count != 0);
	endtask

	task automatic flush_pulse();
		@(negedge clk);
		drive_cycle();
		issue_valid = 1'b0;
		cdb_out_ready = 1'b0; // nothing completes in the flush cycle.
		flush = 1'b1;
		@(negedge clk);
		drive_cycle();
		flush = 1'b0;
	endtask

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		report_error("timeout, the instructions did not all complete in time");
	end

	initial
	begin
		lfsr_state = 32'd32165;
		rst_n = 1'b0;
		flush = 1'b0;
		issue_valid = 1'b0;
		issue = '0;
		cdb_in = '0;
		cdb_out_ready = 1'b0;
		ready_mode = 1;
		test_name = "reset";
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;

		test_name = "direct";
		repeat (30) issue_one(0);
		drain();

		test_name = "external";
		ready_mode = 0;
		repeat (40) issue_one(1);
		drain();

		test_name = "forward";
		repeat (40) issue_one(2);
		drain();

		test_name = "backpressure";
		repeat (4)
		begin
			ready_mode = 2;
			repeat (`RS_COUNT) issue_one(1);
			idle(8); // all stations held while the output stalls.
			ready_mode = 0;
			drain();
		end

		test_name = "flush";
		for (int i = 0; i < 6; i++)
		begin
			ready_mode = (i % 2 == 0) ? 0 : 2; // odd rounds flush with every station full.
			repeat (`RS_COUNT) issue_one(2);
			idle(int'(take_bits(2)));
			flush_pulse();
		end
		ready_mode = 0;
		drain();

		test_name = "random";
		repeat (150) issue_one(2);
		drain();

		if (n_done + n_flushed == n_issued)
		begin
			$display("All tests passed!");
			$finish;
		end
		else
		begin
			report_error("completed and flushed instructions do not add up to those issued");
		end
	end

endmodule : alu_rs_tb

// File: sources.f
+incdir+include
verilog/lc3b_types.sv
verilog/rs_alloc.sv
verilog/alu_res_station.sv
verilog/rs_select.sv
verilog/alu_exec.sv
verilog/alu_rs_unit.sv
tests/alu_rs_tb.sv
